// File: Bender.yml
package:
  name: egr_sch_arb

sources:
  - include_dirs:
      - .
    files:
      - egr_sch_pkg.sv
      - egr_sch_cfg_chain.sv
      - egr_sch_credit.sv
      - egr_sch_pick.sv
      - egr_sch_ctrl.sv
      - egr_sch_arb_wrap.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_egr_sch_arb_wrap.sv

// File: egr_sch_arb_wrap.f
+incdir+.
egr_sch_pkg.sv
egr_sch_cfg_chain.sv
egr_sch_credit.sv
egr_sch_pick.sv
egr_sch_ctrl.sv
egr_sch_arb_wrap.sv
tb_clk_gen.sv
tb_egr_sch_arb_wrap.sv

// File: egr_sch_arb_wrap.sv
// ----------------------------------------------------------
// egress scheduler arbiter top level
// configuration chain, credit, pick and control blocks
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module egr_sch_arb_wrap (
    input  logic                                        clk,
    input  logic                                        arst_n,
    // a request stays up with its cost and payload until its arb_pop
    input  egr_sch_pkg::req_vec_t                       arb,
    input  egr_sch_pkg::cost_t [`EGR_SCH_WIDTH-1:0]     arb_cost,
    input  egr_sch_pkg::payload_t [`EGR_SCH_WIDTH-1:0]  arb_payload,
    output egr_sch_pkg::req_vec_t                       arb_pop,
    // winner side, held until the consumer pops
    output egr_sch_pkg::req_vec_t                       win,
    output egr_sch_pkg::cost_t                          win_cost,
    output egr_sch_pkg::payload_t                       win_payload,
    input  logic                                        pop,
    // serial configuration
    input  logic                                        cfg_shift,
    input  logic                                        cfg_in,
    output logic                                        cfg_out
);

    import egr_sch_pkg::*;

    weight_t [`EGR_SCH_WIDTH-1:0] cfg_weight;
    sched_mode_e                  cfg_mode;
    logic                         cfg_rev;
    logic                         cfg_cost;
    req_vec_t                     eligible;
    logic                         any_eligible;
    req_vec_t                     pick_vec;
    logic                         accept;
    logic                         replenish;

    egr_sch_cfg_chain u_cfg_chain (
        .clk, .arst_n,
        .cfg_shift, .cfg_in, .cfg_out,
        .cfg_weight, .cfg_mode, .cfg_rev, .cfg_cost
    );

    // the registered winner doubles as the grant vector for charging
    egr_sch_credit u_credit (
        .clk, .arst_n,
        .arb, .arb_cost, .cfg_weight, .cfg_cost,
        .accept, .win_vec(win), .replenish,
        .eligible, .any_eligible
    );

    egr_sch_pick u_pick (
        .clk, .arst_n,
        .eligible, .cfg_mode, .cfg_rev,
        .accept, .win_vec(win), .pick_vec
    );

    egr_sch_ctrl u_ctrl (
        .clk, .arst_n,
        .arb, .any_eligible, .pick_vec, .arb_cost, .arb_payload, .pop,
        .win, .win_cost, .win_payload, .arb_pop, .accept, .replenish
    );

endmodule

// File: egr_sch_cfg_chain.sv
// ----------------------------------------------------------
// configuration shift chain of the egress scheduler
// holds the per-requester weights and the rr, rev, cost bits
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module egr_sch_cfg_chain (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          cfg_shift,
    input  logic                                          cfg_in,
    output logic                                          cfg_out,
    output egr_sch_pkg::weight_t [`EGR_SCH_WIDTH-1:0]     cfg_weight,
    output egr_sch_pkg::sched_mode_e                      cfg_mode,
    output logic                                          cfg_rev,
    output logic                                          cfg_cost
);

    import egr_sch_pkg::*;

    // four weights plus three mode bits
    localparam int CHAIN_LEN = `EGR_SCH_WIDTH * $bits(weight_t) + 3;

    logic [CHAIN_LEN-1:0] chain;

    // bits enter at the cost end and travel towards weight 3
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chain <= '0;
        end else if (cfg_shift) begin
            chain <= {chain[CHAIN_LEN-2:0], cfg_in};
        end
    end

    // the top bit of weight 3 is the far end of the chain
    assign cfg_out = chain[CHAIN_LEN-1];

    // ----------------------------------------------------------
    // field map, weight 0 sits just above the three mode bits
    // ----------------------------------------------------------
    assign cfg_weight = chain[CHAIN_LEN-1:3];
    assign cfg_mode   = sched_mode_e'(chain[2]);
    assign cfg_rev    = chain[1];
    assign cfg_cost   = chain[0];

endmodule

// File: egr_sch_credit.sv
// ----------------------------------------------------------
// per-requester deficit counters of the egress scheduler
// eligibility, charge on accept and weight replenish
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module egr_sch_credit (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  egr_sch_pkg::req_vec_t                         arb,
    input  egr_sch_pkg::cost_t [`EGR_SCH_WIDTH-1:0]       arb_cost,
    input  egr_sch_pkg::weight_t [`EGR_SCH_WIDTH-1:0]     cfg_weight,
    input  logic                                          cfg_cost,
    input  logic                                          accept,
    input  egr_sch_pkg::req_vec_t                         win_vec,
    input  logic                                          replenish,
    output egr_sch_pkg::req_vec_t                         eligible,
    output logic                                          any_eligible
);

    import egr_sch_pkg::*;

    deficit_t [`EGR_SCH_WIDTH-1:0] deficit;
    deficit_t [`EGR_SCH_WIDTH-1:0] charge;
    req_vec_t                      counting;

    // ----------------------------------------------------------
    // charge and eligibility
    // ----------------------------------------------------------

    // in deficit mode a request costs its own cost, otherwise
    // every grant takes exactly one credit
    always_comb begin
        for (int i = 0; i < `EGR_SCH_WIDTH; i++) begin
            charge[i]   = cfg_cost ? deficit_t'(arb_cost[i]) : deficit_t'(1);
            counting[i] = (cfg_weight[i] != '0);
            // a zero weight means the requester always has enough credit
            eligible[i] = arb[i] && (!counting[i] || (deficit[i] >= charge[i]));
        end
    end

    assign any_eligible = |eligible;

    // ----------------------------------------------------------
    // deficit counters
    // ----------------------------------------------------------

    // the requester still holds its request on the accept edge, so
    // its cost is valid for the charge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            deficit <= '0;
        end else begin
            for (int i = 0; i < `EGR_SCH_WIDTH; i++) begin
                if (!arb[i] || !counting[i]) begin
                    // an idle queue forfeits its balance
                    deficit[i] <= '0;
                end else if (accept && win_vec[i]) begin
                    // the winner was only eligible with deficit >= charge
                    deficit[i] <= deficit[i] - charge[i];
                end else if (replenish) begin
                    deficit[i] <= deficit[i] + deficit_t'(cfg_weight[i]);
                end
            end
        end
    end

endmodule

// File: egr_sch_ctrl.sv
// ----------------------------------------------------------
// control FSM of the egress scheduler
// registers the winner, offers it and handles accept and
// replenish
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module egr_sch_ctrl (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  egr_sch_pkg::req_vec_t                       arb,
    input  logic                                        any_eligible,
    input  egr_sch_pkg::req_vec_t                       pick_vec,
    input  egr_sch_pkg::cost_t [`EGR_SCH_WIDTH-1:0]     arb_cost,
    input  egr_sch_pkg::payload_t [`EGR_SCH_WIDTH-1:0]  arb_payload,
    input  logic                                        pop,
    output egr_sch_pkg::req_vec_t                       win,
    output egr_sch_pkg::cost_t                          win_cost,
    output egr_sch_pkg::payload_t                       win_payload,
    output egr_sch_pkg::req_vec_t                       arb_pop,
    output logic                                        accept,
    output logic                                        replenish
);

    import egr_sch_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    cost_t       sel_cost;
    payload_t    sel_payload;
    logic        capture;

    // ----------------------------------------------------------
    // next state
    // ----------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // pending requests without credit trigger one refill round
                if (any_eligible) begin
                    state_next = st_offer;
                end else if (|arb) begin
                    state_next = st_replenish;
                end
            end
            st_replenish: state_next = st_idle;
            st_offer: begin
                if (pop) begin
                    state_next = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    assign capture   = (state == st_idle) && any_eligible;
    assign accept    = (state == st_offer) && pop;
    assign replenish = (state == st_replenish);

    // the winner is only ever offered in st_offer, so gating win
    // with accept gives arb_pop
    assign arb_pop = accept ? win : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            win   <= '0;
        end else begin
            state <= state_next;
            if (capture) begin
                win <= pick_vec;
            end else if (accept) begin
                win <= '0;
            end
        end
    end

    // ----------------------------------------------------------
    // winner payload, held steady for the whole offer
    // ----------------------------------------------------------
    always_comb begin
        sel_cost    = '0;
        sel_payload = '0;
        for (int i = 0; i < `EGR_SCH_WIDTH; i++) begin
            if (pick_vec[i]) begin
                sel_cost    = arb_cost[i];
                sel_payload = arb_payload[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            win_cost    <= sel_cost;
            win_payload <= sel_payload;
        end
    end

endmodule

// File: egr_sch_macros.svh
// ----------------------------------------------------------
// egress scheduler arbiter sizing macros
// requester count, weight range, cost range, payload width
// ----------------------------------------------------------

`ifndef EGR_SCH_MACROS_SVH
`define EGR_SCH_MACROS_SVH

// number of requesters competing for the egress slot
`define EGR_SCH_WIDTH 4

// weight range, a weight of up to 99 quanta fits in 7 bits
`define EGR_SCH_TOTAL_QUANTA 100

// cost range for a single request, costs are carried in 8 bits
`define EGR_SCH_MAX_COST 160

// width of the payload that travels with each request
`define EGR_SCH_PAYLOAD 16

`endif

// File: egr_sch_pick.sv
// ----------------------------------------------------------
// winner selection of the egress scheduler
// static priority or round robin, with the round-robin pointer
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module egr_sch_pick (
    input  logic                     clk,
    input  logic                     arst_n,
    input  egr_sch_pkg::req_vec_t    eligible,
    input  egr_sch_pkg::sched_mode_e cfg_mode,
    input  logic                     cfg_rev,
    input  logic                     accept,
    input  egr_sch_pkg::req_vec_t    win_vec,
    output egr_sch_pkg::req_vec_t    pick_vec
);

    import egr_sch_pkg::*;

    localparam int              IDX_W = $clog2(`EGR_SCH_WIDTH);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(`EGR_SCH_WIDTH - 1);

    // all searching is done in search order, which is the requester
    // index itself or its mirror when cfg_rev is set
    req_vec_t         ord_elig;
    logic [IDX_W-1:0] ptr;
    logic [IDX_W-1:0] base;
    logic [IDX_W-1:0] cand;
    logic [IDX_W-1:0] ord_sel;
    logic [IDX_W-1:0] win_idx;
    logic             found;

    always_comb begin
        for (int i = 0; i < `EGR_SCH_WIDTH; i++) begin
            ord_elig[i] = cfg_rev ? eligible[`EGR_SCH_WIDTH-1-i] : eligible[i];
        end
    end

    // ----------------------------------------------------------
    // search, static priority is a round robin that always
    // starts right after the last position
    // ----------------------------------------------------------
    always_comb begin
        base    = (cfg_mode == sched_rr) ? ptr : LAST;
        found   = 1'b0;
        ord_sel = '0;
        for (int k = 1; k <= `EGR_SCH_WIDTH; k++) begin
            cand = IDX_W'((int'(base) + k) % `EGR_SCH_WIDTH);
            if (!found && ord_elig[cand]) begin
                found   = 1'b1;
                ord_sel = cand;
            end
        end
        pick_vec = '0;
        if (found) begin
            pick_vec[cfg_rev ? LAST - ord_sel : ord_sel] = 1'b1;
        end
    end

    // the pointer remembers the last winner in search order, so after
    // reset the first round-robin winner is 0, or 3 when reversed
    always_comb begin
        win_idx = '0;
        for (int i = 0; i < `EGR_SCH_WIDTH; i++) begin
            if (win_vec[i]) begin
                win_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= LAST;
        end else if (accept) begin
            ptr <= cfg_rev ? LAST - win_idx : win_idx;
        end
    end

endmodule

// File: egr_sch_pkg.sv
// ----------------------------------------------------------
// egress scheduler arbiter package
// vector, cost, weight, deficit and payload types
// scheduling mode and control state enums
// ----------------------------------------------------------

`include "egr_sch_macros.svh"

package egr_sch_pkg;

    // one bit per requester, used for requests, eligibility and grants
    typedef logic [`EGR_SCH_WIDTH-1:0] req_vec_t;

    // cost of one request in credits
    typedef logic [$clog2(`EGR_SCH_MAX_COST)-1:0] cost_t;

    // credits added per replenish round, zero disables counting
    typedef logic [$clog2(`EGR_SCH_TOTAL_QUANTA)-1:0] weight_t;

    // one extra bit over a cost so that a leftover balance plus one
    // full weight never wraps
    typedef logic [$clog2(`EGR_SCH_MAX_COST):0] deficit_t;

    typedef logic [`EGR_SCH_PAYLOAD-1:0] payload_t;

    // arbitration mode as stored in the rr bit of the chain
    typedef enum logic {
        sched_prio = 1'b0,
        sched_rr   = 1'b1
    } sched_mode_e;

    // control states of the winner handshake
    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_replenish = 2'd1,
        st_offer     = 2'd2
    } ctrl_state_e;

endpackage

// File: tb_clk_gen.sv
// ----------------------------------------------------------
// testbench clock and reset source
// 100 ns clock, reset held low for the first 10 cycles
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset is released a little after an edge so no flop sees it change on the edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arst_n = 1'b1;
    end

endmodule

// File: tb_egr_sch_arb_wrap.sv
// ----------------------------------------------------------
// directed testbench of the egress scheduler arbiter
// requester queues, consumer, reference model of the
// credit and pick rules, compare tasks and timeout
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "egr_sch_macros.svh"

module tb_egr_sch_arb_wrap;

    import egr_sch_pkg::*;

    localparam int NUM_REQ        = `EGR_SCH_WIDTH;
    localparam int DEPTH          = 16;
    localparam int CFG_BITS       = NUM_REQ * $bits(weight_t) + 3;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                        clk;
    logic                        arst_n;
    req_vec_t                    arb;
    cost_t    [NUM_REQ-1:0]      arb_cost;
    payload_t [NUM_REQ-1:0]      arb_payload;
    req_vec_t                    arb_pop;
    req_vec_t                    win;
    cost_t                       win_cost;
    payload_t                    win_payload;
    logic                        pop;
    logic                        cfg_shift;
    logic                        cfg_in;
    logic                        cfg_out;

    // requester queues as fixed arrays with head and tail indices
    cost_t    q_cost [NUM_REQ][DEPTH];
    payload_t q_pay  [NUM_REQ][DEPTH];
    int       q_head [NUM_REQ];
    int       q_tail [NUM_REQ];

    // configuration as last loaded and the reference model state
    weight_t  exp_weight [NUM_REQ];
    logic     exp_rr;
    logic     exp_rev;
    logic     exp_cost;
    int       model_def [NUM_REQ];
    int       model_pos;

    integer   seed;
    int       errors;
    int       cycle_count = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

    egr_sch_arb_wrap u_egr_sch_arb_wrap (
        .clk(clk), .arst_n(arst_n),
        .arb(arb), .arb_cost(arb_cost), .arb_payload(arb_payload), .arb_pop(arb_pop),
        .win(win), .win_cost(win_cost), .win_payload(win_payload), .pop(pop),
        .cfg_shift(cfg_shift), .cfg_in(cfg_in), .cfg_out(cfg_out)
    );

    // the run is stopped if the tests take far longer than they should
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", errors);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic compare_vec(input string name, input req_vec_t exp, input req_vec_t act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_cost(input string name, input cost_t exp, input cost_t act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_payload(input string name, input payload_t exp, input payload_t act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("Error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    // inputs change 10 ns after the rising edge, outputs are read at the same point
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // ----------------------------------------------------------
    // requester model
    // ----------------------------------------------------------
    function automatic bit has_item(input int i);
        return q_head[i] != q_tail[i];
    endfunction

    task automatic clear_queues();
        for (int i = 0; i < NUM_REQ; i++) begin
            q_head[i]    = 0;
            q_tail[i]    = 0;
            model_def[i] = 0;
        end
    endtask

    task automatic push_item(input int i, input cost_t c);
        q_cost[i][q_tail[i]] = c;
        q_pay[i][q_tail[i]]  = payload_t'($random(seed));
        q_tail[i]++;
    endtask

    // every requester shows the head of its queue until that item is popped
    task automatic drive_requests();
        for (int i = 0; i < NUM_REQ; i++) begin
            arb[i]         = has_item(i);
            arb_cost[i]    = has_item(i) ? q_cost[i][q_head[i]] : '0;
            arb_payload[i] = has_item(i) ? q_pay[i][q_head[i]] : '0;
        end
    endtask

    // the chain is loaded from the far end first, weight 3 top bit leading
    task automatic load_config(input weight_t w3, input weight_t w2, input weight_t w1,
                               input weight_t w0, input logic rr, input logic rev,
                               input logic cst);
        logic [CFG_BITS-1:0] word;
        word = {w3, w2, w1, w0, rr, rev, cst};
        for (int b = CFG_BITS - 1; b >= 0; b--) begin
            cfg_shift = 1'b1;
            cfg_in    = word[b];
            next_cycle();
        end
        cfg_shift     = 1'b0;
        cfg_in        = 1'b0;
        exp_weight[0] = w0;
        exp_weight[1] = w1;
        exp_weight[2] = w2;
        exp_weight[3] = w3;
        exp_rr        = rr;
        exp_rev       = rev;
        exp_cost      = cst;
    endtask

    // ----------------------------------------------------------
    // reference model of the credit and pick rules
    // ----------------------------------------------------------
    function automatic int charge_of(input int i);
        if (exp_cost && has_item(i)) begin
            return int'(q_cost[i][q_head[i]]);
        end
        return 1;
    endfunction

    function automatic req_vec_t model_eligible();
        req_vec_t e;
        for (int i = 0; i < NUM_REQ; i++) begin
            e[i] = has_item(i) && (exp_weight[i] == 0 || model_def[i] >= charge_of(i));
        end
        return e;
    endfunction

    // refill rounds run until someone is eligible, then the search starts
    // after the last winner in search order, or after the last position
    // in static priority
    task automatic model_grant(output int idx);
        req_vec_t elig;
        int       rounds;
        int       base;
        int       pos;
        int       r;
        idx    = -1;
        rounds = 0;
        elig   = model_eligible();
        while (elig == '0 && rounds < 64) begin
            for (int i = 0; i < NUM_REQ; i++) begin
                if (has_item(i) && exp_weight[i] != 0) begin
                    model_def[i] += int'(exp_weight[i]);
                end
            end
            rounds++;
            elig = model_eligible();
        end
        base = exp_rr ? model_pos : NUM_REQ - 1;
        for (int k = 1; k <= NUM_REQ; k++) begin
            pos = (base + k) % NUM_REQ;
            r   = exp_rev ? NUM_REQ - 1 - pos : pos;
            if (idx < 0 && elig[r]) begin
                idx = r;
            end
        end
        if (idx >= 0) begin
            if (exp_weight[idx] != 0) begin
                model_def[idx] -= charge_of(idx);
            end
            model_pos = exp_rev ? NUM_REQ - 1 - idx : idx;
        end
    endtask

    // ----------------------------------------------------------
    // consumer, waits for a winner and pops it after hold cycles
    // ----------------------------------------------------------
    task automatic serve_one(input int hold);
        int       exp_idx;
        req_vec_t exp_vec;
        cost_t    exp_c;
        payload_t exp_p;
        req_vec_t popped;
        model_grant(exp_idx);
        if (exp_idx < 0) begin
            errors++;
            $display("the reference model found no requester that could win at %0t", $time);
            return;
        end
        exp_vec = req_vec_t'(1) << exp_idx;
        exp_c   = q_cost[exp_idx][q_head[exp_idx]];
        exp_p   = q_pay[exp_idx][q_head[exp_idx]];
        while (win == '0) begin
            next_cycle();
        end
        compare_vec("win", exp_vec, win);
        compare_cost("win_cost", exp_c, win_cost);
        compare_payload("win_payload", exp_p, win_payload);
        // under back-pressure the offer must not move
        for (int h = 0; h < hold; h++) begin
            compare_vec("arb_pop", '0, arb_pop);
            next_cycle();
            compare_vec("win", exp_vec, win);
            compare_cost("win_cost", exp_c, win_cost);
            compare_payload("win_payload", exp_p, win_payload);
        end
        pop = 1'b1;
        #1;
        popped = arb_pop;
        compare_vec("arb_pop", exp_vec, popped);
        next_cycle();
        pop = 1'b0;
        compare_vec("win", '0, win);
        // requesters react to their own arb_pop bit
        for (int i = 0; i < NUM_REQ; i++) begin
            if (popped[i] && has_item(i)) begin
                q_head[i]++;
                if (!has_item(i)) begin
                    model_def[i] = 0;
                end
            end
        end
        drive_requests();
    endtask

    task automatic run_grants(input int count, input int hold);
        for (int g = 0; g < count; g++) begin
            serve_one(hold);
        end
        repeat (3) next_cycle();
        compare_vec("win", '0, win);
        for (int i = 0; i < NUM_REQ; i++) begin
            if (has_item(i)) begin
                errors++;
                $display("requester %0d still has items queued after its test", i);
            end
        end
    endtask

    // ----------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------
    task automatic test_chain_readback();
        logic [CFG_BITS-1:0] pattern;
        pattern = 31'h2a5c_96e1;
        for (int b = CFG_BITS - 1; b >= 0; b--) begin
            cfg_shift = 1'b1;
            cfg_in    = pattern[b];
            next_cycle();
        end
        // zeros follow the pattern so the chain ends up cleared
        for (int b = CFG_BITS - 1; b >= 0; b--) begin
            compare_bit("cfg_out", pattern[b], cfg_out);
            cfg_in = 1'b0;
            next_cycle();
        end
        cfg_shift = 1'b0;
        load_config('0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_static_priority();
        load_config('0, '0, '0, '0, 1'b0, 1'b0, 1'b0);
        clear_queues();
        push_item(0, 8'd3);
        push_item(0, 8'd4);
        push_item(0, 8'd5);
        push_item(1, 8'd6);
        push_item(1, 8'd7);
        push_item(2, 8'd8);
        push_item(3, 8'd9);
        drive_requests();
        run_grants(7, 0);
        // reversed direction favours requester 3
        load_config('0, '0, '0, '0, 1'b0, 1'b1, 1'b0);
        clear_queues();
        push_item(3, 8'd10);
        push_item(3, 8'd11);
        push_item(3, 8'd12);
        push_item(2, 8'd13);
        push_item(1, 8'd14);
        push_item(0, 8'd15);
        push_item(0, 8'd16);
        drive_requests();
        run_grants(7, 0);
    endtask

    task automatic test_round_robin();
        for (int rev = 0; rev < 2; rev++) begin
            load_config('0, '0, '0, '0, 1'b1, logic'(rev), 1'b0);
            clear_queues();
            for (int i = 0; i < NUM_REQ; i++) begin
                push_item(i, cost_t'(8'h20 + i));
                push_item(i, cost_t'(8'h30 + i));
            end
            drive_requests();
            run_grants(2 * NUM_REQ, 0);
        end
    endtask

    task automatic test_deficit_rr();
        load_config(7'd0, 7'd40, 7'd20, 7'd10, 1'b1, 1'b0, 1'b1);
        clear_queues();
        push_item(0, 8'd15);
        push_item(0, 8'd8);
        push_item(0, 8'd12);
        push_item(1, 8'd30);
        push_item(1, 8'd10);
        push_item(1, 8'd25);
        push_item(2, 8'd50);
        push_item(2, 8'd20);
        push_item(2, 8'd35);
        push_item(3, 8'd5);
        push_item(3, 8'd60);
        drive_requests();
        run_grants(11, 0);
    endtask

    task automatic test_backpressure();
        load_config('0, '0, '0, '0, 1'b1, 1'b0, 1'b0);
        clear_queues();
        for (int i = 0; i < NUM_REQ; i++) begin
            push_item(i, cost_t'($random(seed)));
        end
        drive_requests();
        for (int g = 0; g < NUM_REQ; g++) begin
            serve_one(3 + 2 * g);
        end
        run_grants(0, 0);
    endtask

    initial begin
        seed        = 32'h5e36_451d;
        errors      = 0;
        arb         = '0;
        arb_cost    = '0;
        arb_payload = '0;
        pop         = 1'b0;
        cfg_shift   = 1'b0;
        cfg_in      = 1'b0;
        model_pos   = NUM_REQ - 1;
        clear_queues();
        for (int i = 0; i < NUM_REQ; i++) begin
            exp_weight[i] = '0;
        end
        exp_rr   = 1'b0;
        exp_rev  = 1'b0;
        exp_cost = 1'b0;
        wait (arst_n === 1'b1);
        next_cycle();
        test_chain_readback();
        test_static_priority();
        test_round_robin();
        test_deficit_rr();
        test_backpressure();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
